// ==== Bender.yml ====
package:
  name: uart_demo

sources:
  - common/uart_pkg.sv
  - common/demo_pkg.sv
  - uart/uart_tx.sv
  - uart/uart_rx.sv
  - hdl/code_sequencer.sv
  - hdl/uart_demo_top.sv
  - target: test
    files:
      - tests/tb_uart_demo.sv

// ==== common/demo_pkg.sv ====
`default_nettype none

package demo_pkg;

    // short startup wait so the sequencer starts quickly in simulation.
    localparam int startup_cycles = 64;

    localparam int code_bits = 6;  // codes wrap after 63.

    // one demo code sent zero extended to a byte.
    typedef logic [code_bits-1:0] code_t;

    // startup counter up to startup_cycles - 1.
    typedef logic [$clog2(startup_cycles)-1:0] startup_count_t;

    // board leds {red, green, blue} are active low.
    typedef logic [2:0] led_t;

    localparam logic led_off = 1'b1;
    localparam logic led_on  = 1'b0;

    // code sequencer FSM.
    typedef enum logic {
        init,  // waiting out the startup interval.
        run    // streaming codes.
    } seq_state_t;

endpackage

`default_nettype wire

// ==== common/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    // line format is 1 start, 8 data lsb first, even parity, 1 stop.
    localparam int clks_per_bit = 8;   // no fractional baud.
    localparam int data_bits    = 8;
    localparam int frame_bits   = 11;  // start + data + parity + stop.

    // one payload byte.
    typedef logic [data_bits-1:0] uart_byte_t;

    // bit position within a frame.
    typedef logic [3:0] bit_count_t;

    // clock count within one bit period.
    typedef logic [$clog2(clks_per_bit)-1:0] baud_count_t;

    // result of one received frame.
    typedef struct packed {
        uart_byte_t data;
        logic       parity_error;  // set when parity bit breaks even parity.
    } uart_rx_result_t;

endpackage

`default_nettype wire

// ==== hdl/code_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module code_sequencer (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  tx_busy,
    output logic                 start_tx,
    output uart_pkg::uart_byte_t tx_data,
    output demo_pkg::led_t       led
);

    demo_pkg::seq_state_t     state;
    demo_pkg::startup_count_t startup_count;
    demo_pkg::code_t          code;       // next code to send.
    logic                     tx_busy_q;  // for falling edge detect.

    logic tx_done;

    assign tx_done = tx_busy_q && !tx_busy;

    // payload byte that goes with start_tx.
    always_ff @(posedge clk) begin
        if ((state == demo_pkg::init &&
             startup_count == demo_pkg::startup_count_t'(demo_pkg::startup_cycles - 1)) ||
            (state == demo_pkg::run && tx_done)) begin
            tx_data <= uart_pkg::uart_byte_t'(code);  // upper bits zero.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= demo_pkg::init;
            startup_count <= '0;
            code          <= '0;
            tx_busy_q     <= 1'b0;
            start_tx      <= 1'b0;
            led           <= {demo_pkg::led_off, demo_pkg::led_off, demo_pkg::led_off};
        end else begin
            tx_busy_q <= tx_busy;
            start_tx  <= 1'b0;
            case (state)
                demo_pkg::init: begin
                    startup_count <= startup_count + 1'b1;
                    if (startup_count ==
                        demo_pkg::startup_count_t'(demo_pkg::startup_cycles - 1)) begin
                        state    <= demo_pkg::run;
                        start_tx <= 1'b1;  // code 0 goes out first.
                        code     <= code + 1'b1;
                        // blue on while red and green stay off.
                        led      <= {demo_pkg::led_off, demo_pkg::led_off, demo_pkg::led_on};
                    end
                end
                demo_pkg::run: begin
                    if (tx_done) begin
                        start_tx <= 1'b1;
                        code     <= code + 1'b1;  // wraps after 63.
                    end
                end
                default: begin
                    state <= demo_pkg::init;
                end
            endcase
        end
    end

    a_single_strobe : assert property (
        @(posedge clk) disable iff (reset)
        start_tx |=> !start_tx
    ) else $error("code_sequencer: start_tx high two cycles in a row");

endmodule

`default_nettype wire

// ==== hdl/uart_demo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_demo_top (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  rx,
    output wire                  tx,
    output demo_pkg::led_t       led,
    output demo_pkg::code_t      code_out,
    output wire                  parity_error,
    output wire                  rx_done
);

    // sequencer to transmitter.
    logic                 start_tx;
    uart_pkg::uart_byte_t tx_data;
    logic                 tx_busy;

    // last received frame, held until the next one.
    uart_pkg::uart_rx_result_t rx_result;

    code_sequencer i_code_sequencer (
        .clk      (clk),
        .reset    (reset),
        .tx_busy  (tx_busy),
        .start_tx (start_tx),
        .tx_data  (tx_data),
        .led      (led)
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .reset    (reset),
        .start_tx (start_tx),
        .tx_data  (tx_data),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    // receive path runs independently of the transmitter.
    uart_rx i_uart_rx (
        .clk       (clk),
        .reset     (reset),
        .rx        (rx),
        .rx_result (rx_result),
        .rx_done   (rx_done)
    );

    // only the low six bits reach the pins.
    assign code_out     = rx_result.data[demo_pkg::code_bits-1:0];
    assign parity_error = rx_result.parity_error;

endmodule

`default_nettype wire

// ==== list.f ====
common/uart_pkg.sv
common/demo_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
hdl/code_sequencer.sv
hdl/uart_demo_top.sv
tests/tb_uart_demo.sv

// ==== tests/tb_uart_demo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart_demo;

    localparam int clk_period = 4;
    localparam int bit_cycles = uart_pkg::clks_per_bit;
    localparam int frame_cycles = uart_pkg::frame_bits * uart_pkg::clks_per_bit;
    localparam int watchdog_cycles = (demo_pkg::startup_cycles + 80 * frame_cycles) * 3 / 2;
    localparam int tx_frames_needed = 72;  // covers the wrap after 63.
    localparam int random_frames = 20;
    localparam int rx_done_expected = random_frames + 3;  // bad stop frame gives none.

    localparam demo_pkg::led_t led_dark = {3{demo_pkg::led_off}};
    localparam demo_pkg::led_t led_blue = {demo_pkg::led_off, demo_pkg::led_off, demo_pkg::led_on};

    logic            clk;
    logic            reset;
    logic            rx;
    wire             tx;
    demo_pkg::led_t  led;
    demo_pkg::code_t code_out;
    wire             parity_error;
    wire             rx_done;

    int     cycle_count;       // clocks since reset release.
    int     rx_done_count = 0;
    int     tx_frames = 0;
    integer seed;

    uart_demo_top i_uart_demo_top (
        .clk          (clk),
        .reset        (reset),
        .rx           (rx),
        .tx           (tx),
        .led          (led),
        .code_out     (code_out),
        .parity_error (parity_error),
        .rx_done      (rx_done)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_reset_levels();
        expect_equal("tx", 1, tx);
        expect_equal("led", led_dark, led);
        expect_equal("code_out", 0, code_out);
        expect_equal("parity_error", 0, parity_error);
        expect_equal("rx_done", 0, rx_done);
    endtask

    // starts 1 ns after a rising edge and returns at the same phase.
    task automatic drive_rx_bit(input logic value);
        rx = value;
        repeat (bit_cycles) @(posedge clk);
        #1;
    endtask

    task automatic send_rx_frame(input uart_pkg::uart_byte_t data, input logic bad_parity,
                                 input logic bad_stop);
        int              done_before;
        demo_pkg::code_t code_before;
        int              b;
        done_before = rx_done_count;
        code_before = code_out;
        drive_rx_bit(1'b0);  // start bit.
        for (b = 0; b < uart_pkg::data_bits; b++) begin
            drive_rx_bit(data[b]);
        end
        drive_rx_bit(^data ^ bad_parity);
        drive_rx_bit(!bad_stop);
        drive_rx_bit(1'b1);  // idle bit before the checks.
        if (bad_stop) begin
            expect_equal("rx_done count", done_before, rx_done_count);
            expect_equal("code_out", code_before, code_out);
        end else begin
            expect_equal("rx_done count", done_before + 1, rx_done_count);
            expect_equal("code_out", data[demo_pkg::code_bits-1:0], code_out);
            expect_equal("parity_error", bad_parity, parity_error);
        end
    endtask

    // counts clocks from reset release.
    always @(posedge clk) begin
        if (reset) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    always @(posedge clk) begin
        if (!reset && rx_done) begin
            rx_done_count <= rx_done_count + 1;  // a long pulse counts twice.
        end
    end

    a_tx_quiet_at_startup : assert property (
        @(posedge clk) disable iff (reset)
        (cycle_count < demo_pkg::startup_cycles) |-> tx
    ) else begin
        $display("** Error at %0t: tx expected 1, got %b", $time, $sampled(tx));
        stop_with_failure();
    end

    a_led_follows_startup : assert property (
        @(posedge clk) disable iff (reset)
        led == ((cycle_count >= demo_pkg::startup_cycles) ? led_blue : led_dark)
    ) else begin
        $display("** Error at %0t: led expected %b, got %b", $time,
                 ($sampled(cycle_count) >= demo_pkg::startup_cycles) ? led_blue : led_dark,
                 $sampled(led));
        stop_with_failure();
    end

    initial begin
        reset = 1'b1;
        rx    = 1'b1;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #1;
            if (i > 0) begin
                check_reset_levels();  // first edge only loads the reset values.
            end
        end
        reset = 1'b0;
        @(posedge clk);
        #1;
        check_reset_levels();
    end

    // decodes tx at mid bit and follows the code count.
    initial begin : tx_monitor
        uart_pkg::uart_byte_t data;
        logic                 parity;
        demo_pkg::code_t      expected_code;
        expected_code = '0;
        wait (reset === 1'b0);
        forever begin
            @(negedge tx);
            repeat (bit_cycles / 2) @(posedge clk);
            expect_equal("tx start bit", 0, tx);
            for (int b = 0; b < uart_pkg::data_bits; b++) begin
                repeat (bit_cycles) @(posedge clk);
                data[b] = tx;
            end
            repeat (bit_cycles) @(posedge clk);
            parity = tx;
            repeat (bit_cycles) @(posedge clk);
            expect_equal("tx stop bit", 1, tx);
            expect_equal("tx parity bit", ^data, parity);
            expect_equal("tx data", uart_pkg::uart_byte_t'(expected_code), data);
            expected_code = expected_code + 1'b1;  // wraps after 63.
            tx_frames = tx_frames + 1;
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles, run did not complete", watchdog_cycles);
        stop_with_failure();
    end

    initial begin : main
        uart_pkg::uart_byte_t data;
        seed = 32'h7530_0605;
        wait (reset === 1'b0);
        @(posedge clk);
        #1;
        // receive traffic overlaps the tx stream.
        for (int n = 0; n < random_frames; n++) begin
            data = uart_pkg::uart_byte_t'($random(seed));
            send_rx_frame(data, 1'b0, 1'b0);
        end
        data = uart_pkg::uart_byte_t'($random(seed));
        send_rx_frame(data, 1'b1, 1'b0);  // flipped parity.
        data = uart_pkg::uart_byte_t'($random(seed));
        send_rx_frame(data, 1'b0, 1'b1);  // low stop bit.
        for (int n = 0; n < 2; n++) begin
            data = uart_pkg::uart_byte_t'($random(seed));
            send_rx_frame(data, 1'b0, 1'b0);
        end
        wait (tx_frames >= tx_frames_needed);
        if (rx_done_count == rx_done_expected) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("** Error at %0t: rx_done count expected %0d, got %0d", $time,
                     rx_done_expected, rx_done_count);
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

// ==== uart/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          rx,
    output uart_pkg::uart_rx_result_t    rx_result,
    output logic                         rx_done
);

    typedef enum logic [2:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_parity,
        rx_stop
    } rx_state_t;

    rx_state_t state;

    logic rx_meta;
    logic rx_sync;
    logic rx_last;  // previous synced value for edge detect.

    uart_pkg::baud_count_t baud_count;
    uart_pkg::bit_count_t  bit_count;
    uart_pkg::uart_byte_t  shift_data;
    logic                  parity_bit;

    logic mid_start;
    logic bit_end;

    // two flop synchronizer that resets to the idle level.
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    assign mid_start = (baud_count == uart_pkg::baud_count_t'(uart_pkg::clks_per_bit / 2 - 1));
    assign bit_end   = (baud_count == uart_pkg::baud_count_t'(uart_pkg::clks_per_bit - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= rx_idle;
            baud_count <= '0;
            bit_count  <= '0;
            shift_data <= '0;
            parity_bit <= 1'b0;
            rx_result  <= '0;
            rx_done    <= 1'b0;
        end else begin
            rx_done    <= 1'b0;
            baud_count <= baud_count + 1'b1;
            case (state)
                rx_idle: begin
                    baud_count <= '0;
                    if (rx_last && !rx_sync) begin
                        state <= rx_start;  // falling edge.
                    end
                end
                rx_start: begin
                    if (mid_start) begin
                        // from here on every count wraps at mid bit.
                        baud_count <= '0;
                        bit_count  <= '0;
                        state      <= rx_sync ? rx_idle : rx_data;  // false start.
                    end
                end
                rx_data: begin
                    if (bit_end) begin
                        baud_count <= '0;
                        shift_data <= {rx_sync, shift_data[uart_pkg::data_bits-1:1]};
                        if (bit_count == uart_pkg::bit_count_t'(uart_pkg::data_bits - 1)) begin
                            state <= rx_parity;
                        end else begin
                            bit_count <= bit_count + 1'b1;
                        end
                    end
                end
                rx_parity: begin
                    if (bit_end) begin
                        baud_count <= '0;
                        parity_bit <= rx_sync;
                        state      <= rx_stop;
                    end
                end
                rx_stop: begin
                    if (bit_end) begin
                        baud_count <= '0;
                        state      <= rx_idle;
                        if (rx_sync) begin
                            rx_done                <= 1'b1;
                            rx_result.data         <= shift_data;
                            rx_result.parity_error <= parity_bit ^ (^shift_data);
                        end
                        // a low stop bit drops the frame.
                    end
                end
                default: begin
                    state <= rx_idle;
                end
            endcase
        end
    end

    a_done_one_cycle : assert property (
        @(posedge clk) disable iff (reset)
        rx_done |=> !rx_done
    ) else $error("uart_rx: rx_done longer than one cycle");

    // a full frame less half a bit must pass between two results.
    a_done_spacing : assert property (
        @(posedge clk) disable iff (reset)
        rx_done |=> !rx_done [*(uart_pkg::frame_bits * uart_pkg::clks_per_bit
                                - uart_pkg::clks_per_bit / 2)]
    ) else $error("uart_rx: rx_done within one frame of the last");

endmodule

`default_nettype wire

// ==== uart/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 start_tx,
    input  wire uart_pkg::uart_byte_t tx_data,
    output logic                tx,
    output logic                tx_busy
);

    // bits still to go after the current one with the lsb next.
    logic [uart_pkg::frame_bits-2:0] shifter;
    uart_pkg::baud_count_t           baud_count;
    uart_pkg::bit_count_t            bit_count;  // bits already finished.

    logic bit_end;

    assign bit_end = (baud_count == uart_pkg::baud_count_t'(uart_pkg::clks_per_bit - 1));

    // frame shift register, loaded on start.
    always_ff @(posedge clk) begin
        if (!tx_busy && start_tx) begin
            // stop, even parity, then data lsb first.
            shifter <= {1'b1, ^tx_data, tx_data};
        end else if (tx_busy && bit_end) begin
            shifter <= {1'b1, shifter[uart_pkg::frame_bits-2:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tx         <= 1'b1;  // line idles high.
            tx_busy    <= 1'b0;
            baud_count <= '0;
            bit_count  <= '0;
        end else if (!tx_busy) begin
            baud_count <= '0;
            bit_count  <= '0;
            if (start_tx) begin
                tx      <= 1'b0;  // start bit.
                tx_busy <= 1'b1;
            end
        end else if (bit_end) begin
            baud_count <= '0;
            if (bit_count == uart_pkg::bit_count_t'(uart_pkg::frame_bits - 1)) begin
                // end of stop bit.
                tx        <= 1'b1;
                tx_busy   <= 1'b0;
                bit_count <= '0;
            end else begin
                tx        <= shifter[0];
                bit_count <= bit_count + 1'b1;
            end
        end else begin
            baud_count <= baud_count + 1'b1;
        end
    end

    // the sender has to wait for idle; nothing here queues a second byte.
    a_start_only_when_idle : assert property (
        @(posedge clk) disable iff (reset)
        start_tx |-> !tx_busy
    ) else $error("uart_tx: start_tx while tx_busy is high");

    // line must rest high between frames.
    a_idle_line_high : assert property (
        @(posedge clk) disable iff (reset)
        !tx_busy |-> tx
    ) else $error("uart_tx: tx low while idle");

endmodule

`default_nettype wire
